// ==== src/aexmCore_params.svh ====
`ifndef AEXMCORE_PARAMS_SVH
`define AEXMCORE_PARAMS_SVH

`define AEMB_DW   32
`define AEMB_NREG 32
`define AEMB_BSF  1              // Barrel shifter present

// Major opcodes
`define AEMB_OPC_MOVE   6'o45
`define AEMB_OPC_SHIFT  6'o44
`define AEMB_OPC_BARREL 6'o21
`define AEMB_OPC_LOGIC  6'o40   // Base of or/and/xor/andn

// Result mux codes
`define AEMB_ALU_ADD    3'd0
`define AEMB_ALU_LOGIC  3'd1
`define AEMB_ALU_SHIFT  3'd2
`define AEMB_ALU_MOVE   3'd3
`define AEMB_ALU_BARREL 3'd5
`define AEMB_ALU_NONE   3'd7

// Operand source codes
`define AEMB_SEL_REG 2'd0
`define AEMB_SEL_FWD 2'd1
`define AEMB_SEL_IMM 2'd3

`endif

// ==== src/aexmPkg.sv ====
`default_nettype none

`include "aexmCore_params.svh"

package aexmPkg;

   // Data or instruction word
   typedef logic [`AEMB_DW-1:0] word_t;

   // Register index, 5 bits for 32 registers
   typedef logic [$clog2(`AEMB_NREG)-1:0] regIdx_t;

   // Major opcode, inst[31:26]
   typedef logic [5:0] opcode_t;

   // Immediate field, inst[15:0]
   typedef logic [15:0] imm_t;

   // Result mux select
   // 0 add, 1 logic, 2 shift, 3 move, 5 barrel; 4, 6 and 7 are reserved
   typedef logic [2:0] aluSel_t;

   // Operand source: 0 register, 1 forwarded result, 3 immediate
   typedef logic [1:0] opSel_t;

endpackage

`default_nettype wire

// ==== src/aexmRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aexmCore_params.svh"

module aexmRegFile (
   input  wire                     gclk,
   input  wire                     arstN,
   input  wire aexmPkg::regIdx_t   raIdx,
   input  wire aexmPkg::regIdx_t   rbIdx,
   output aexmPkg::word_t          regA,
   output aexmPkg::word_t          regB,
   input  wire                     wrValid,
   input  wire aexmPkg::regIdx_t   wrIdx,
   input  wire aexmPkg::word_t     wrData
);

   aexmPkg::word_t regs [`AEMB_NREG];

   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `AEMB_NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (wrValid && wrIdx != '0) begin
         regs[wrIdx] <= wrData;             // r0 never written
      end
   end

   // Write-through so a pending write is seen in the same cycle
   assign regA = (wrValid && wrIdx == raIdx && raIdx != '0) ? wrData : regs[raIdx];
   assign regB = (wrValid && wrIdx == rbIdx && rbIdx != '0) ? wrData : regs[rbIdx];

   wrIdxKnown: assert property (@(posedge gclk) disable iff (!arstN)
      wrValid |-> !$isunknown(wrIdx));

endmodule

`default_nettype wire

// ==== src/aexmDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aexmCore_params.svh"

module aexmDecode (
   input  wire                     gclk,
   input  wire                     arstN,
   input  wire                     instValid,
   input  wire aexmPkg::word_t     inst,
   input  wire aexmPkg::word_t     regA,
   input  wire aexmPkg::word_t     regB,
   input  wire aexmPkg::word_t     xResult,
   input  wire aexmPkg::regIdx_t   xRd,
   input  wire                     xWrEn,
   input  wire                     xCarry,
   output aexmPkg::regIdx_t        raIdx,
   output aexmPkg::regIdx_t        rbIdx,
   output logic                    opValid,
   output aexmPkg::opcode_t        opc,
   output aexmPkg::imm_t           imm,
   output aexmPkg::regIdx_t        rd,
   output aexmPkg::regIdx_t        ra,
   output aexmPkg::aluSel_t        aluSel,
   output logic                    wrEn,
   output aexmPkg::opSel_t         selA,
   output aexmPkg::opSel_t         selB,
   output logic                    carryIn,
   output logic                    subOp,
   output aexmPkg::word_t          operandA,
   output aexmPkg::word_t          operandB
);

   aexmPkg::word_t   instReg;
   aexmPkg::regIdx_t rb;
   logic             addGrp;
   logic             carryUse;
   logic             isMts;

   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         opValid <= 1'b0;
      end else begin
         opValid <= instValid;
      end
   end

   always_ff @(posedge gclk) begin
      instReg <= inst;
   end

   // Field split
   assign opc = instReg[31:26];
   assign rd  = instReg[25:21];
   assign ra  = instReg[20:16];
   assign rb  = instReg[15:11];
   assign imm = instReg[15:0];
   assign raIdx = ra;
   assign rbIdx = rb;

   assign addGrp   = (opc[5:4] == 2'b00);
   assign subOp    = addGrp & opc[0];    // rsub family
   assign carryUse = addGrp & opc[1];    // addc/rsubc family
   assign isMts    = (opc == `AEMB_OPC_MOVE) & imm[14];
   assign wrEn     = !isMts;

   always_comb begin
      if (addGrp) begin
         aluSel = `AEMB_ALU_ADD;
      end else if ((opc & 6'o64) == `AEMB_OPC_LOGIC) begin
         aluSel = `AEMB_ALU_LOGIC;
      end else if (opc == `AEMB_OPC_SHIFT) begin
         aluSel = `AEMB_ALU_SHIFT;
      end else if (opc == `AEMB_OPC_MOVE) begin
         aluSel = `AEMB_ALU_MOVE;
      end else if ((opc & 6'o67) == `AEMB_OPC_BARREL) begin
         aluSel = `AEMB_ALU_BARREL;
      end else begin
         aluSel = `AEMB_ALU_NONE;        // Not an opcode this core handles
      end
   end

   // Only the instruction in execute can be ahead of the regfile
   assign selA = (xWrEn && xRd == ra && ra != '0) ? `AEMB_SEL_FWD : `AEMB_SEL_REG;
   assign selB = opc[3] ? `AEMB_SEL_IMM :
                 (xWrEn && xRd == rb && rb != '0) ? `AEMB_SEL_FWD : `AEMB_SEL_REG;

   assign operandA = (selA == `AEMB_SEL_FWD) ? xResult : regA;

   always_comb begin
      case (selB)
         `AEMB_SEL_FWD: operandB = xResult;
         `AEMB_SEL_IMM: operandB = {{(`AEMB_DW-16){imm[15]}}, imm};
         default:       operandB = regB;
      endcase
   end

   // Carry chained from the executing instruction's next C
   assign carryIn = carryUse ? xCarry : subOp;

   instValidKnown: assert property (@(posedge gclk) disable iff (!arstN)
      !$isunknown(instValid));

endmodule

`default_nettype wire

// ==== src/aexmExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aexmCore_params.svh"

module aexmExecute (
   input  wire                     gclk,
   input  wire                     arstN,
   input  wire                     opValid,
   input  wire aexmPkg::opcode_t   opc,
   input  wire aexmPkg::imm_t      imm,
   input  wire aexmPkg::regIdx_t   rd,
   input  wire aexmPkg::regIdx_t   ra,
   input  wire aexmPkg::aluSel_t   aluSel,
   input  wire                     wrEn,
   input  wire                     subOp,
   input  wire                     carryIn,
   input  wire aexmPkg::word_t     operandA,
   input  wire aexmPkg::word_t     operandB,
   output aexmPkg::word_t          xResult,
   output aexmPkg::regIdx_t        xRd,
   output logic                    xWrEn,
   output logic                    xCarry,
   output logic                    wrValid,
   output aexmPkg::regIdx_t        wrIdx,
   output aexmPkg::word_t          wrData,
   output aexmPkg::word_t          msr,
   output logic                    msrIe
);

   aexmPkg::word_t   opA;
   aexmPkg::word_t   opB;
   logic             cIn;
   logic             xValid;
   logic             xWrReq;
   aexmPkg::opcode_t xOpc;
   aexmPkg::imm_t    xImm;
   aexmPkg::regIdx_t xRa;
   aexmPkg::aluSel_t xSel;

   logic             msrC;
   logic             msrBip;
   logic             msrBe;

   logic [`AEMB_DW:0] sum;
   aexmPkg::word_t   logRes;
   aexmPkg::word_t   sftRes;
   aexmPkg::word_t   bsfRes;
   aexmPkg::word_t   movRes;
   aexmPkg::word_t   msrImg;
   logic [4:0]       shAmt;
   logic             fMfs;
   logic             fMts;

   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         xValid <= 1'b0;
      end else begin
         xValid <= opValid;
      end
   end

   // Operand latches, A inverted so rsub reuses the adder
   always_ff @(posedge gclk) begin
      opA    <= subOp ? ~operandA : operandA;
      opB    <= operandB;
      cIn    <= carryIn;
      xOpc   <= opc;
      xImm   <= imm;
      xRd    <= rd;
      xRa    <= ra;
      xSel   <= aluSel;
      xWrReq <= wrEn;
   end

   assign xWrEn = xValid & xWrReq;

   assign sum = {1'b0, opB} + {1'b0, opA} + {{`AEMB_DW{1'b0}}, cIn};

   always_comb begin
      case (xOpc[1:0])
         2'd0: logRes = opA | opB;
         2'd1: logRes = opA & opB;
         2'd2: logRes = opA ^ opB;
         default: logRes = opA & ~opB;    // andn
      endcase
   end

   // sra, src, srl, then sext8/sext16 on imm[0]
   always_comb begin
      case (xImm[6:5])
         2'd0: sftRes = {opA[`AEMB_DW-1], opA[`AEMB_DW-1:1]};
         2'd1: sftRes = {msrC, opA[`AEMB_DW-1:1]};
         2'd2: sftRes = {1'b0, opA[`AEMB_DW-1:1]};
         default: begin
            if (xImm[0]) begin
               sftRes = {{(`AEMB_DW-16){opA[15]}}, opA[15:0]};
            end else begin
               sftRes = {{(`AEMB_DW-8){opA[7]}}, opA[7:0]};
            end
         end
      endcase
   end

   assign shAmt = opB[4:0];

   always_comb begin
      case (xImm[10:9])
         2'd1: bsfRes = $signed(opA) >>> shAmt;   // bsra
         2'd2: bsfRes = opA << shAmt;             // bsll
         default: bsfRes = opA >> shAmt;          // bsrl
      endcase
   end

   // MSR image, C mirrored in the top bit
   assign msrImg = {msrC, {(`AEMB_DW-5){1'b0}}, msrBip, msrC, msrIe, msrBe};
   assign msr    = msrImg;

   assign fMfs   = (xOpc == `AEMB_OPC_MOVE) & !xImm[14] & xImm[0];
   assign fMts   = (xOpc == `AEMB_OPC_MOVE) & xImm[14] & xValid;
   assign movRes = fMfs ? msrImg : (xRa[3] ? opB : opA);

   always_comb begin
      case (xSel)
         `AEMB_ALU_ADD:    xResult = sum[`AEMB_DW-1:0];
         `AEMB_ALU_LOGIC:  xResult = logRes;
         `AEMB_ALU_SHIFT:  xResult = sftRes;
         `AEMB_ALU_MOVE:   xResult = movRes;
         `AEMB_ALU_BARREL: xResult = (`AEMB_BSF != 0) ? bsfRes : '0;
         default:          xResult = '0;
      endcase
   end

   // Next carry, also chained back to decode
   always_comb begin
      xCarry = msrC;
      if (xValid) begin
         case (xSel)
            `AEMB_ALU_ADD: begin
               if (!xOpc[2]) begin
                  xCarry = sum[`AEMB_DW];  // Keep variants hold C
               end
            end
            `AEMB_ALU_SHIFT: begin
               if (xImm[6:5] != 2'd3) begin
                  xCarry = opA[0];         // Bit shifted out
               end
            end
            `AEMB_ALU_MOVE: begin
               if (fMts) begin
                  xCarry = opA[2];
               end
            end
            default: xCarry = msrC;
         endcase
      end
   end

   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         msrC    <= 1'b0;
         msrIe   <= 1'b0;
         msrBip  <= 1'b0;
         msrBe   <= 1'b0;
         wrValid <= 1'b0;
      end else begin
         msrC    <= xCarry;
         wrValid <= xWrEn;
         if (fMts) begin
            msrIe  <= opA[1];
            msrBip <= opA[3];
            msrBe  <= opA[0];
         end
      end
   end

   // Result register, doubles as retire port
   always_ff @(posedge gclk) begin
      wrIdx  <= xRd;
      wrData <= xResult;
   end

   aluSelLegal: assert property (@(posedge gclk) disable iff (!arstN)
      opValid |-> aluSel inside {`AEMB_ALU_ADD, `AEMB_ALU_LOGIC, `AEMB_ALU_SHIFT,
                                 `AEMB_ALU_MOVE, `AEMB_ALU_BARREL});

endmodule

`default_nettype wire

// ==== src/aexmCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module aexmCore (
   input  wire                     gclk,
   input  wire                     arstN,
   input  wire                     instValid,
   input  wire aexmPkg::word_t     inst,
   output logic                    retireValid,
   output aexmPkg::regIdx_t        retireRd,
   output aexmPkg::word_t          retireData,
   output aexmPkg::word_t          msr,
   output logic                    msrIe
);

   aexmPkg::regIdx_t raIdx;
   aexmPkg::regIdx_t rbIdx;
   aexmPkg::word_t   regA;
   aexmPkg::word_t   regB;
   logic             opValid;
   aexmPkg::opcode_t opc;
   aexmPkg::imm_t    imm;
   aexmPkg::regIdx_t rd;
   aexmPkg::regIdx_t ra;
   aexmPkg::aluSel_t aluSel;
   logic             wrEn;
   logic             carryIn;
   logic             subOp;
   aexmPkg::word_t   operandA;
   aexmPkg::word_t   operandB;
   aexmPkg::word_t   xResult;
   aexmPkg::regIdx_t xRd;
   logic             xWrEn;
   logic             xCarry;

   aexmDecode u_decode (
      .gclk(gclk), .arstN(arstN), .instValid(instValid), .inst(inst),
      .regA(regA), .regB(regB),
      .xResult(xResult), .xRd(xRd), .xWrEn(xWrEn), .xCarry(xCarry),
      .raIdx(raIdx), .rbIdx(rbIdx), .opValid(opValid),
      .opc(opc), .imm(imm), .rd(rd), .ra(ra),
      .aluSel(aluSel), .wrEn(wrEn),
      .selA(), .selB(),                   // Mux selects stay inside decode
      .carryIn(carryIn), .subOp(subOp),
      .operandA(operandA), .operandB(operandB)
   );

   // Retire port is the regfile write port
   aexmRegFile u_regs (
      .gclk(gclk), .arstN(arstN),
      .raIdx(raIdx), .rbIdx(rbIdx), .regA(regA), .regB(regB),
      .wrValid(retireValid), .wrIdx(retireRd), .wrData(retireData)
   );

   aexmExecute u_exec (
      .gclk(gclk), .arstN(arstN), .opValid(opValid),
      .opc(opc), .imm(imm), .rd(rd), .ra(ra),
      .aluSel(aluSel), .wrEn(wrEn), .subOp(subOp), .carryIn(carryIn),
      .operandA(operandA), .operandB(operandB),
      .xResult(xResult), .xRd(xRd), .xWrEn(xWrEn), .xCarry(xCarry),
      .wrValid(retireValid), .wrIdx(retireRd), .wrData(retireData),
      .msr(msr), .msrIe(msrIe)
   );

endmodule

`default_nettype wire

// ==== tests/aexmClkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module aexmClkGen (
   output logic gclk,
   output logic arstN
);

   initial begin
      gclk = 1'b0;
      forever #20 gclk = ~gclk;         // 40 ns period
   end

   initial begin
      arstN = 1'b0;
      repeat (3) @(posedge gclk);
      #5 arstN = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/aexmCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aexmCore_params.svh"

module aexmCoreTb;

   logic gclk;
   logic arstN;
   logic instValid;
   aexmPkg::word_t inst;
   logic retireValid;
   aexmPkg::regIdx_t retireRd;
   aexmPkg::word_t retireData;
   aexmPkg::word_t msr;
   logic msrIe;

   aexmPkg::word_t prog [$];
   bit progV [$];
   bit expWr [$];
   aexmPkg::regIdx_t expRd [$];
   aexmPkg::word_t expData [$];
   aexmPkg::word_t expMsr [$];
   aexmPkg::word_t modelRegs [32];
   aexmPkg::word_t lastMsr = '0;
   logic mC, mIe, mBip, mBe;
   logic [31:0] rngState = 32'd80;
   logic [2:0] doneSh;
   int pushed = 0;
   int checked = 0;
   bit progReady = 0;

   aexmClkGen u_clk (.gclk(gclk), .arstN(arstN));

   aexmCore u_dut (
      .gclk(gclk), .arstN(arstN), .instValid(instValid), .inst(inst),
      .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData),
      .msr(msr), .msrIe(msrIe)
   );

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic checkWord(input string name, input aexmPkg::word_t got,
                            input aexmPkg::word_t exp);
      if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
   endtask

   task automatic checkReg(input string name, input aexmPkg::regIdx_t got,
                           input aexmPkg::regIdx_t exp);
      if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
   endtask

   function logic [31:0] nextRand();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic aexmPkg::word_t enc(input aexmPkg::opcode_t op, input aexmPkg::regIdx_t rd,
                                          input aexmPkg::regIdx_t ra, input aexmPkg::imm_t im);
      return {op, rd, ra, im};
   endfunction

   function automatic bit isWrite(input aexmPkg::word_t ins);
      return !(ins[31:26] == `AEMB_OPC_MOVE && ins[14]);
   endfunction

   // Instruction set model run in program order
   function aexmPkg::word_t refExec(input aexmPkg::word_t ins);
      aexmPkg::opcode_t op;
      aexmPkg::imm_t im;
      aexmPkg::word_t a;
      aexmPkg::word_t b;
      aexmPkg::word_t res;
      logic [32:0] s;
      logic cin;
      logic [4:0] sh;
      op = ins[31:26];
      im = ins[15:0];
      a = modelRegs[ins[20:16]];
      b = op[3] ? {{16{im[15]}}, im} : modelRegs[ins[15:11]];
      res = '0;
      if (op[5:4] == 2'b00) begin
         cin = op[1] ? mC : op[0];
         s = {1'b0, b} + {1'b0, (op[0] ? ~a : a)} + {32'd0, cin};
         res = s[31:0];
         if (!op[2]) mC = s[32];
      end else if ((op & 6'o64) == `AEMB_OPC_LOGIC) begin
         case (op[1:0])
            2'd0: res = a | b;
            2'd1: res = a & b;
            2'd2: res = a ^ b;
            default: res = a & ~b;
         endcase
      end else if (op == `AEMB_OPC_SHIFT) begin
         case (im[6:5])
            2'd0: res = {a[31], a[31:1]};
            2'd1: res = {mC, a[31:1]};
            2'd2: res = {1'b0, a[31:1]};
            default: res = im[0] ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
         endcase
         if (im[6:5] != 2'd3) mC = a[0];
      end else if (op == `AEMB_OPC_MOVE) begin
         if (im[14]) begin              // mts
            mIe = a[1];
            mBip = a[3];
            mBe = a[0];
            mC = a[2];
         end else begin
            res = {mC, 27'd0, mBip, mC, mIe, mBe};
         end
      end else begin
         sh = b[4:0];
         case (im[10:9])
            2'd1: res = aexmPkg::word_t'($signed(a) >>> sh);
            2'd2: res = a << sh;
            default: res = a >> sh;
         endcase
      end
      if (isWrite(ins) && ins[25:21] != 5'd0) modelRegs[ins[25:21]] = res;
      return res;
   endfunction

   function aexmPkg::word_t randomInst();
      logic [31:0] r;
      logic [31:0] f;
      aexmPkg::opcode_t op;
      aexmPkg::imm_t im;
      r = nextRand();
      f = nextRand();
      im = f[31:16];
      case (r % 6)
         0, 1: op = {2'b00, r[11:8]};
         2: op = (r[12] ? 6'o50 : 6'o40) | {4'd0, r[9:8]};
         3: begin
            op = `AEMB_OPC_SHIFT;
            im[6:0] = (r[10:8] < 3'd4) ? {r[9:8], 5'd0} : 7'h61;
         end
         4: begin
            op = r[12] ? 6'o31 : `AEMB_OPC_BARREL;
            im[10:9] = (r[9:8] == 2'd3) ? 2'd1 : r[9:8];
         end
         default: begin
            op = `AEMB_OPC_MOVE;
            im[14] = r[8];
            im[0] = 1'b1;
         end
      endcase
      return enc(op, {2'b00, f[2:0]}, {2'b00, f[5:3]}, im);
   endfunction

   task automatic addInst(input aexmPkg::word_t w);
      prog.push_back(w);
      progV.push_back(1'b1);
   endtask

   // Directed list followed by random traffic with bubbles
   task automatic buildProgram();
      logic [31:0] r;
      addInst(enc(6'o00, 5'd2, 5'd0, 16'h0000));      // add r2,r0,r0
      addInst(enc(6'o10, 5'd1, 5'd0, 16'hFFFF));      // addi r1 = -1
      addInst(enc(6'o10, 5'd2, 5'd0, 16'h0001));
      addInst(enc(6'o00, 5'd3, 5'd1, {5'd2, 11'd0})); // carry out with forwarded r2
      addInst(enc(6'o04, 5'd4, 5'd1, {5'd2, 11'd0})); // addk
      addInst(enc(6'o02, 5'd5, 5'd2, {5'd2, 11'd0})); // addc
      addInst(enc(6'o01, 5'd6, 5'd2, {5'd1, 11'd0})); // rsub
      addInst(enc(6'o03, 5'd7, 5'd1, {5'd6, 11'd0})); // rsubc
      addInst(enc(6'o11, 5'd8, 5'd3, 16'h0100));      // rsubi
      addInst(enc(6'o12, 5'd9, 5'd8, 16'h7FFF));      // addic
      addInst(enc(6'o15, 5'd10, 5'd9, 16'h8000));     // rsubik
      addInst(enc(6'o16, 5'd11, 5'd10, 16'h1234));    // addikc
      for (int i = 0; i < 4; i++) addInst(enc(6'o40 | 6'(i), 5'd12, 5'd9, {5'd11, 11'd0}));
      addInst(enc(6'o50, 5'd13, 5'd12, 16'hA5A5));    // ori
      addInst(enc(6'o10, 5'd14, 5'd0, 16'h8083));
      addInst(enc(`AEMB_OPC_SHIFT, 5'd15, 5'd14, 16'h0000));
      addInst(enc(`AEMB_OPC_SHIFT, 5'd15, 5'd15, 16'h0020));
      addInst(enc(`AEMB_OPC_SHIFT, 5'd15, 5'd14, 16'h0040));
      addInst(enc(`AEMB_OPC_SHIFT, 5'd16, 5'd14, 16'h0060));
      addInst(enc(`AEMB_OPC_SHIFT, 5'd16, 5'd14, 16'h0061));
      for (int t = 0; t < 3; t++) begin
         for (int s = 0; s < 32; s++) begin
            addInst(enc(6'o31, 5'd17, 5'd14, 16'(t << 9) | 16'(s)));
         end
      end
      addInst(enc(`AEMB_OPC_BARREL, 5'd18, 5'd14, {5'd2, 2'd1, 9'd0}));
      addInst(enc(6'o10, 5'd19, 5'd0, 16'h000F));
      addInst(enc(`AEMB_OPC_MOVE, 5'd0, 5'd19, 16'h4001));   // mts all bits set
      addInst(enc(`AEMB_OPC_MOVE, 5'd20, 5'd0, 16'h0001));   // mfs
      addInst(enc(6'o10, 5'd19, 5'd0, 16'h0002));
      addInst(enc(`AEMB_OPC_MOVE, 5'd0, 5'd19, 16'h4001));
      addInst(enc(`AEMB_OPC_MOVE, 5'd21, 5'd0, 16'h0001));
      addInst(enc(6'o00, 5'd0, 5'd1, {5'd1, 11'd0}));        // write to r0
      addInst(enc(6'o00, 5'd22, 5'd0, {5'd0, 11'd0}));
      for (int i = 0; i < 300; i++) begin
         r = nextRand();
         if (r[2:0] == 3'd0) begin
            prog.push_back('0);
            progV.push_back(1'b0);
         end
         addInst(randomInst());
      end
   endtask

   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) doneSh <= '0;
      else doneSh <= {doneSh[1:0], instValid};
   end

   // Compare process sampled mid cycle
   always @(negedge gclk) begin
      if (arstN) begin
         if (retireValid && expWr.size() == 0) begin
            failRun("retire seen with no instruction outstanding");
         end
         if (doneSh[2]) begin
            checkBit("retireValid", retireValid, expWr[0]);
            if (expWr[0]) begin
               checkReg("retireRd", retireRd, expRd[0]);
               checkWord("retireData", retireData, expData[0]);
            end
            checkWord("msr", msr, expMsr[0]);
            checkBit("msrIe", msrIe, expMsr[0][1]);
            lastMsr = expMsr[0];
            void'(expWr.pop_front());
            void'(expRd.pop_front());
            void'(expData.pop_front());
            void'(expMsr.pop_front());
            checked++;
         end else begin
            checkBit("retireValid", retireValid, 1'b0);
            checkWord("msr", msr, lastMsr);         // MSR holds between retires
            checkBit("msrIe", msrIe, lastMsr[1]);
         end
      end
   end

   initial begin
      wait (progReady);
      #((prog.size() + 20) * 40);
      failRun("retirement stalled before all instructions completed");
   end

   initial begin
      aexmPkg::word_t res;
      instValid = 1'b0;
      inst = '0;
      for (int i = 0; i < 32; i++) modelRegs[i] = '0;
      {mC, mIe, mBip, mBe} = 4'b0;
      buildProgram();
      progReady = 1;
      wait (arstN);
      checkBit("retireValid", retireValid, 1'b0);
      checkWord("msr", msr, '0);
      checkBit("msrIe", msrIe, 1'b0);
      for (int i = 0; i < prog.size(); i++) begin
         @(posedge gclk);
         #2;
         instValid = progV[i];
         inst = prog[i];
         if (progV[i]) begin
            res = refExec(prog[i]);
            expWr.push_back(isWrite(prog[i]));
            expRd.push_back(prog[i][25:21]);
            expData.push_back(res);
            expMsr.push_back({mC, 27'd0, mBip, mC, mIe, mBe});
            pushed++;
         end
      end
      @(posedge gclk);
      #2 instValid = 1'b0;
      while (checked < pushed) @(negedge gclk);
      repeat (2) @(posedge gclk);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== aexmCore.f ====
+incdir+src
src/aexmPkg.sv
src/aexmRegFile.sv
src/aexmDecode.sv
src/aexmExecute.sv
src/aexmCore.sv
tests/aexmClkGen.sv
tests/aexmCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the aexmCore testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f aexmCore.f \
   --top-module aexmCoreTb \
   -o aexmCoreSim

./obj_dir/aexmCoreSim
